// File: logic/eth_mmio_macros.svh
`ifndef ETH_MMIO_MACROS_SVH
`define ETH_MMIO_MACROS_SVH

// Bus and register widths
`define ETH_MMIO_ADDR_W 32
`define ETH_MMIO_DATA_W 64
`define ETH_MMIO_IDX_W 3
`define ETH_MMIO_IDX_LSB 3
`define ETH_MMIO_NUM_REGS 6

// Payload beat layout inside a register word
`define ETH_BEAT_BYTES 7
`define ETH_BEAT_DATA_W (`ETH_BEAT_BYTES * 8)
`define ETH_BEAT_SIZE_W 3
`define ETH_BEAT_PAD_W 3

// Register map
`define ETH_REG_TX_SRC 3'd0
`define ETH_REG_TX_DST_TYPE 3'd1
`define ETH_REG_TX_DATA 3'd2
`define ETH_REG_RX_SRC 3'd3
`define ETH_REG_RX_DST_TYPE 3'd4
`define ETH_REG_RX_DATA 3'd5

// AXI response codes
`define AXI_RESP_OKAY 2'd0
`define AXI_RESP_SLVERR 2'd2

`endif

// File: logic/eth_mmio_pkg.sv
`default_nettype none

`include "eth_mmio_macros.svh"

package eth_mmio_pkg;

    // Frame header as carried on the header streams, 112 bits
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [`ETH_BEAT_DATA_W-1:0] data;
        logic [`ETH_BEAT_BYTES-1:0] keep;
        logic last;
    } eth_beat_t;

    // Field view of a reg 2 / reg 5 word
    typedef struct packed {
        logic valid;
        logic last;
        logic [`ETH_BEAT_PAD_W-1:0] pad;
        logic [`ETH_BEAT_SIZE_W-1:0] size;
        logic [`ETH_BEAT_DATA_W-1:0] data;
    } beat_fields_t;

    typedef union packed {
        logic [`ETH_MMIO_DATA_W-1:0] raw;
        beat_fields_t f;
    } beat_word_t;

    typedef struct packed {
        logic [`ETH_MMIO_DATA_W-1:0] data;
        logic [1:0] resp;
    } axil_rd_t;

    typedef struct packed {
        logic [`ETH_MMIO_IDX_W-1:0] idx;
        logic bad;
    } mmio_access_t;

    // Low byte-offset bits are dropped, anything above the index is an error
    function automatic mmio_access_t decode_addr(input logic [`ETH_MMIO_ADDR_W-1:0] addr);
        mmio_access_t acc;
        acc.idx = addr[`ETH_MMIO_IDX_LSB +: `ETH_MMIO_IDX_W];
        acc.bad = |addr[`ETH_MMIO_ADDR_W-1:`ETH_MMIO_IDX_LSB+`ETH_MMIO_IDX_W];
        return acc;
    endfunction

endpackage

`default_nettype wire

// File: logic/axil_read_channel.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module axil_read_channel (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  logic [`ETH_MMIO_ADDR_W-1:0] ar_addr,
    output logic                        r_valid,
    input  logic                        r_ready,
    output eth_mmio_pkg::axil_rd_t      r_rd,
    output logic                        rd_fire,
    output eth_mmio_pkg::mmio_access_t  rd_acc,
    input  eth_mmio_pkg::axil_rd_t      rd_out
);
    import eth_mmio_pkg::*;

    logic ar_fire;
    logic out_free;
    logic pend_valid;
    logic pend_next;
    mmio_access_t pend_acc;

    assign ar_fire = ar_valid && ar_ready;

    // Output register can take new data this cycle
    assign out_free = !r_valid || r_ready;

    // A buffered address always goes before the bus address
    assign rd_acc = pend_valid ? pend_acc : decode_addr(ar_addr);
    assign rd_fire = (pend_valid || ar_fire) && out_free;

    assign pend_next = (ar_fire && !out_free) || (pend_valid && !rd_fire);

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            // Only one address may wait behind a stalled response
            ar_ready <= !pend_next;
            pend_valid <= pend_next;
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire && !out_free) begin
            pend_acc <= decode_addr(ar_addr);
        end
        if (rd_fire) begin
            r_rd <= rd_out;
        end
    end

endmodule

`default_nettype wire

// File: logic/axil_write_channel.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module axil_write_channel (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  logic [`ETH_MMIO_ADDR_W-1:0] aw_addr,
    input  logic                        w_valid,
    output logic                        w_ready,
    input  logic [`ETH_MMIO_DATA_W-1:0] w_data,
    output logic                        b_valid,
    input  logic                        b_ready,
    output logic [1:0]                  b_resp,
    input  logic                        wr_allow,
    input  logic [1:0]                  wr_resp,
    output logic                        wr_fire,
    output eth_mmio_pkg::mmio_access_t  wr_acc,
    output logic [`ETH_MMIO_DATA_W-1:0] wr_data
);
    import eth_mmio_pkg::*;

    logic aw_fire;
    logic w_fire;
    logic aw_held;
    logic w_held;
    logic aw_have;
    logic w_have;
    logic aw_held_next;
    logic w_held_next;
    logic b_free;
    mmio_access_t aw_acc_q;
    logic [`ETH_MMIO_DATA_W-1:0] w_data_q;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire = w_valid && w_ready;

    // Each half counts as present from the cycle of its own transfer
    assign aw_have = aw_held || aw_fire;
    assign w_have = w_held || w_fire;

    assign wr_acc = aw_held ? aw_acc_q : decode_addr(aw_addr);
    assign wr_data = w_held ? w_data_q : w_data;

    assign b_free = !b_valid || b_ready;
    assign wr_fire = aw_have && w_have && b_free && wr_allow;

    assign aw_held_next = aw_have && !wr_fire;
    assign w_held_next = w_have && !wr_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            aw_held <= aw_held_next;
            w_held <= w_held_next;
            aw_ready <= !aw_held_next;
            // Stop taking data while the held address targets a full stager
            w_ready <= !w_held_next && !(aw_held_next && !wr_allow);
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire && !wr_fire) begin
            aw_acc_q <= decode_addr(aw_addr);
        end
        if (w_fire && !wr_fire) begin
            w_data_q <= w_data;
        end
        if (wr_fire) begin
            b_resp <= wr_resp;
        end
    end

endmodule

`default_nettype wire

// File: logic/eth_mmio_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module eth_mmio_control (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_fire,
    input  eth_mmio_pkg::mmio_access_t  rd_acc,
    output eth_mmio_pkg::axil_rd_t      rd_out,
    input  logic                        wr_fire,
    input  eth_mmio_pkg::mmio_access_t  wr_acc,
    input  logic [`ETH_MMIO_DATA_W-1:0] wr_data,
    output logic [1:0]                  wr_resp,
    output logic                        wr_allow,
    output logic                        rx_pop,
    input  eth_mmio_pkg::beat_word_t    rx_word,
    input  eth_mmio_pkg::eth_hdr_t      rx_hdr_cap,
    input  logic                        tx_full,
    output logic                        tx_push,
    output eth_mmio_pkg::beat_word_t    tx_word,
    output eth_mmio_pkg::eth_hdr_t      tx_hdr_src
);

    logic [47:0] tx_src;
    logic [`ETH_MMIO_DATA_W-1:0] tx_dst_type;
    logic wr_to_tx;

    // Read decode
    always_comb begin
        rd_out.data = '0;
        rd_out.resp = `AXI_RESP_OKAY;
        if (rd_acc.bad) begin
            rd_out.resp = `AXI_RESP_SLVERR;
        end else begin
            case (rd_acc.idx)
                `ETH_REG_TX_SRC: rd_out.data = {16'h0, tx_src};
                `ETH_REG_TX_DST_TYPE: rd_out.data = tx_dst_type;
                `ETH_REG_RX_SRC: rd_out.data = {16'h0, rx_hdr_cap.src_mac};
                `ETH_REG_RX_DST_TYPE: rd_out.data = {rx_hdr_cap.eth_type, rx_hdr_cap.dst_mac};
                `ETH_REG_RX_DATA: rd_out.data = rx_word.raw;
                // Reg 2 is write only
                default: rd_out.resp = `AXI_RESP_SLVERR;
            endcase
        end
    end

    assign rx_pop = rd_fire && !rd_acc.bad && rd_acc.idx == `ETH_REG_RX_DATA;

    // Write decode
    assign wr_to_tx = !wr_acc.bad && wr_acc.idx == `ETH_REG_TX_DATA;
    assign wr_resp = (wr_acc.bad || wr_acc.idx >= `ETH_MMIO_NUM_REGS) ?
                     `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    assign wr_allow = !(wr_to_tx && tx_full);

    assign tx_push = wr_fire && wr_to_tx;
    assign tx_word = wr_data;

    // Header for the next frame start, taken straight from regs 0 and 1
    assign tx_hdr_src.dst_mac = tx_dst_type[47:0];
    assign tx_hdr_src.src_mac = tx_src;
    assign tx_hdr_src.eth_type = tx_dst_type[63:48];

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_src <= '0;
            tx_dst_type <= '0;
        end else if (wr_fire && !wr_acc.bad) begin
            if (wr_acc.idx == `ETH_REG_TX_SRC) begin
                tx_src <= wr_data[47:0];
            end
            if (wr_acc.idx == `ETH_REG_TX_DST_TYPE) begin
                tx_dst_type <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/tx_frame_stager.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module tx_frame_stager (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tx_push,
    input  eth_mmio_pkg::beat_word_t tx_word,
    input  eth_mmio_pkg::eth_hdr_t   tx_hdr_src,
    output logic                     tx_full,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output eth_mmio_pkg::eth_hdr_t   tx_hdr,
    output logic                     tx_beat_valid,
    input  logic                     tx_beat_ready,
    output eth_mmio_pkg::eth_beat_t  tx_beat
);

    logic in_frame;
    logic [`ETH_BEAT_BYTES-1:0] push_keep;

    // Size n becomes the low n keep bits
    assign push_keep = {`ETH_BEAT_BYTES{1'b1}} >>
                       (`ETH_BEAT_SIZE_W'(`ETH_BEAT_BYTES) - tx_word.f.size);

    // Busy until both the beat and a pending header have gone out
    assign tx_full = tx_beat_valid || tx_hdr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
            tx_beat_valid <= 1'b0;
            in_frame <= 1'b0;
        end else if (tx_push) begin
            tx_beat_valid <= 1'b1;
            tx_hdr_valid <= !in_frame;
            in_frame <= !tx_word.f.last;
        end else begin
            if (tx_beat_ready) begin
                tx_beat_valid <= 1'b0;
            end
            if (tx_hdr_ready) begin
                tx_hdr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_push) begin
            tx_beat.data <= tx_word.f.data;
            tx_beat.keep <= push_keep;
            tx_beat.last <= tx_word.f.last;
            if (!in_frame) begin
                tx_hdr <= tx_hdr_src;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rx_frame_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module rx_frame_reader (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_pop,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  eth_mmio_pkg::eth_hdr_t   rx_hdr,
    input  logic                     rx_beat_valid,
    output logic                     rx_beat_ready,
    input  eth_mmio_pkg::eth_beat_t  rx_beat,
    output eth_mmio_pkg::beat_word_t rx_word,
    output eth_mmio_pkg::eth_hdr_t   rx_hdr_cap
);

    logic in_frame;
    logic beat_avail;
    logic [`ETH_BEAT_SIZE_W-1:0] beat_size;

    // A frame start needs its header too
    assign beat_avail = rx_beat_valid && (in_frame || rx_hdr_valid);

    // Keep is contiguous, so counting ones gives the byte count
    always_comb begin
        beat_size = '0;
        for (int i = 0; i < `ETH_BEAT_BYTES; i++) begin
            beat_size = beat_size + {{(`ETH_BEAT_SIZE_W-1){1'b0}}, rx_beat.keep[i]};
        end
    end

    always_comb begin
        rx_word.raw = '0;
        if (beat_avail) begin
            rx_word.f.valid = 1'b1;
            rx_word.f.last = rx_beat.last;
            rx_word.f.size = beat_size;
            rx_word.f.data = rx_beat.data;
        end
    end

    assign rx_beat_ready = rx_pop && beat_avail;
    assign rx_hdr_ready = rx_pop && beat_avail && !in_frame;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else if (rx_beat_ready) begin
            in_frame <= !rx_beat.last;
        end
    end

    // Regs 3 and 4 follow the frame whose first beat was read
    always_ff @(posedge clk) begin
        if (rx_hdr_ready) begin
            rx_hdr_cap <= rx_hdr;
        end
    end

endmodule

`default_nettype wire

// File: logic/eth_mmio_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module eth_mmio_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  logic [`ETH_MMIO_ADDR_W-1:0] aw_addr,
    input  logic                        w_valid,
    output logic                        w_ready,
    input  logic [`ETH_MMIO_DATA_W-1:0] w_data,
    output logic                        b_valid,
    input  logic                        b_ready,
    output logic [1:0]                  b_resp,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  logic [`ETH_MMIO_ADDR_W-1:0] ar_addr,
    output logic                        r_valid,
    input  logic                        r_ready,
    output eth_mmio_pkg::axil_rd_t      r_rd,
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output eth_mmio_pkg::eth_hdr_t      tx_hdr,
    output logic                        tx_beat_valid,
    input  logic                        tx_beat_ready,
    output eth_mmio_pkg::eth_beat_t     tx_beat,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  eth_mmio_pkg::eth_hdr_t      rx_hdr,
    input  logic                        rx_beat_valid,
    output logic                        rx_beat_ready,
    input  eth_mmio_pkg::eth_beat_t     rx_beat
);
    import eth_mmio_pkg::*;

    logic rd_fire;
    mmio_access_t rd_acc;
    axil_rd_t rd_out;
    logic wr_fire;
    mmio_access_t wr_acc;
    logic [`ETH_MMIO_DATA_W-1:0] wr_data;
    logic [1:0] wr_resp;
    logic wr_allow;
    logic rx_pop;
    beat_word_t rx_word;
    eth_hdr_t rx_hdr_cap;
    logic tx_full;
    logic tx_push;
    beat_word_t tx_word;
    eth_hdr_t tx_hdr_src;

    axil_read_channel u_rd (
        .clk(clk), .rst(rst),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_rd(r_rd),
        .rd_fire(rd_fire), .rd_acc(rd_acc), .rd_out(rd_out)
    );

    axil_write_channel u_wr (
        .clk(clk), .rst(rst),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .wr_allow(wr_allow), .wr_resp(wr_resp),
        .wr_fire(wr_fire), .wr_acc(wr_acc), .wr_data(wr_data)
    );

    eth_mmio_control u_ctrl (
        .clk(clk), .rst(rst),
        .rd_fire(rd_fire), .rd_acc(rd_acc), .rd_out(rd_out),
        .wr_fire(wr_fire), .wr_acc(wr_acc), .wr_data(wr_data),
        .wr_resp(wr_resp), .wr_allow(wr_allow),
        .rx_pop(rx_pop), .rx_word(rx_word), .rx_hdr_cap(rx_hdr_cap),
        .tx_full(tx_full), .tx_push(tx_push), .tx_word(tx_word), .tx_hdr_src(tx_hdr_src)
    );

    tx_frame_stager u_tx (
        .clk(clk), .rst(rst),
        .tx_push(tx_push), .tx_word(tx_word), .tx_hdr_src(tx_hdr_src), .tx_full(tx_full),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready), .tx_hdr(tx_hdr),
        .tx_beat_valid(tx_beat_valid), .tx_beat_ready(tx_beat_ready), .tx_beat(tx_beat)
    );

    rx_frame_reader u_rx (
        .clk(clk), .rst(rst), .rx_pop(rx_pop),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready), .rx_hdr(rx_hdr),
        .rx_beat_valid(rx_beat_valid), .rx_beat_ready(rx_beat_ready), .rx_beat(rx_beat),
        .rx_word(rx_word), .rx_hdr_cap(rx_hdr_cap)
    );

endmodule

`default_nettype wire

// File: test/tb_eth_mmio.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mmio_macros.svh"

module tb_eth_mmio;
    import eth_mmio_pkg::*;

    // Roughly 100 bus accesses of up to 20 cycles each, with a tenfold margin
    localparam int WATCHDOG_CYCLES = 100 * 20 * 10;

    logic clk;
    logic rst;
    logic aw_valid;
    logic aw_ready;
    logic [`ETH_MMIO_ADDR_W-1:0] aw_addr;
    logic w_valid;
    logic w_ready;
    logic [`ETH_MMIO_DATA_W-1:0] w_data;
    logic b_valid;
    logic b_ready;
    logic [1:0] b_resp;
    logic ar_valid;
    logic ar_ready;
    logic [`ETH_MMIO_ADDR_W-1:0] ar_addr;
    logic r_valid;
    logic r_ready;
    axil_rd_t r_rd;
    logic tx_hdr_valid;
    logic tx_hdr_ready;
    eth_hdr_t tx_hdr;
    logic tx_beat_valid;
    logic tx_beat_ready;
    eth_beat_t tx_beat;
    logic rx_hdr_valid;
    logic rx_hdr_ready;
    eth_hdr_t rx_hdr;
    logic rx_beat_valid;
    logic rx_beat_ready;
    eth_beat_t rx_beat;

    int seed = 32'ha8b9;
    int sink_seed = 32'ha8b9;

    // Expected contents of regs 0 and 1
    logic [63:0] tx_src_m;
    logic [63:0] tx_dst_m;

    eth_hdr_t tx_hdr_exp[$];
    eth_hdr_t tx_hdr_seen[$];
    eth_beat_t tx_beat_exp[$];
    eth_beat_t tx_beat_seen[$];
    eth_hdr_t rx_hdr_q[$];
    eth_beat_t rx_beat_q[$];
    logic rx_hdr_taken;
    logic rx_beat_taken;

    eth_mmio_top UUT (.*);

    always #50 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Register index to byte address, with random offset bits below the index
    function automatic logic [31:0] reg_addr(input int idx);
        return (idx << 3) | (32'($random(seed)) & 32'h7);
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic write_reg(input logic [31:0] addr, input logic [63:0] data,
                             input logic [1:0] exp_resp);
        bit aw_done;
        bit w_done;
        bit b_done;
        int wait_n;
        aw_done = 0;
        w_done = 0;
        b_done = 0;
        wait_n = $random(seed) & 3;
        aw_valid = 1'b1;
        aw_addr = addr;
        w_valid = 1'b1;
        w_data = data;
        while (!b_done) begin
            if (wait_n == 0) begin
                b_ready = 1'b1;
            end
            @(negedge clk);
            aw_done = aw_done || (aw_valid && aw_ready);
            w_done = w_done || (w_valid && w_ready);
            if (b_valid && b_ready) begin
                check_value("b_resp", b_resp, exp_resp);
                b_done = 1;
            end
            @(posedge clk);
            #10;
            aw_valid = aw_valid && !aw_done;
            w_valid = w_valid && !w_done;
            if (wait_n > 0) begin
                wait_n--;
            end
        end
        b_ready = 1'b0;
    endtask

    task automatic issue_ar(input logic [31:0] addr);
        bit fire;
        fire = 0;
        ar_valid = 1'b1;
        ar_addr = addr;
        while (!fire) begin
            @(negedge clk);
            fire = ar_ready;
            @(posedge clk);
            #10;
        end
        ar_valid = 1'b0;
    endtask

    // Holds r_ready low for a few cycles and watches r_rd while it waits
    task automatic collect_r(input logic [63:0] exp_data, input logic [1:0] exp_resp);
        axil_rd_t held;
        bit seen;
        bit fire;
        int wait_n;
        seen = 0;
        fire = 0;
        wait_n = $random(seed) & 3;
        while (!fire) begin
            if (wait_n == 0) begin
                r_ready = 1'b1;
            end
            @(negedge clk);
            if (r_valid) begin
                if (seen) begin
                    check_value("r_rd held", r_rd, held);
                end
                held = r_rd;
                seen = 1;
                fire = r_ready;
            end
            @(posedge clk);
            #10;
            if (wait_n > 0) begin
                wait_n--;
            end
        end
        r_ready = 1'b0;
        check_value("r_rd", held, {exp_data, exp_resp});
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [63:0] exp_data,
                            input logic [1:0] exp_resp);
        issue_ar(addr);
        collect_r(exp_data, exp_resp);
    endtask

    task automatic set_tx_regs();
        logic [63:0] wdata;
        wdata = rand64();
        write_reg(reg_addr(`ETH_REG_TX_SRC), wdata, `AXI_RESP_OKAY);
        tx_src_m = {16'h0, wdata[47:0]};
        wdata = rand64();
        write_reg(reg_addr(`ETH_REG_TX_DST_TYPE), wdata, `AXI_RESP_OKAY);
        tx_dst_m = wdata;
    endtask

    task automatic send_frame(input int n_beats, input bit change_regs);
        beat_word_t word;
        eth_beat_t beat;
        eth_hdr_t hdr;
        logic [63:0] wdata;
        int i;
        hdr.dst_mac = tx_dst_m[47:0];
        hdr.src_mac = tx_src_m[47:0];
        hdr.eth_type = tx_dst_m[63:48];
        tx_hdr_exp.push_back(hdr);
        for (i = 0; i < n_beats; i++) begin
            wdata = rand64();
            word.raw = '0;
            word.f.valid = 1'b1;
            word.f.last = (i == n_beats - 1);
            word.f.size = $random(seed) & 7;
            word.f.data = wdata[55:0];
            beat.data = wdata[55:0];
            beat.keep = `ETH_BEAT_BYTES'((8'd1 << word.f.size) - 8'd1);
            beat.last = word.f.last;
            tx_beat_exp.push_back(beat);
            write_reg(reg_addr(`ETH_REG_TX_DATA), word.raw, `AXI_RESP_OKAY);
            // Header of the running frame is already latched
            if (i == 0 && change_regs) begin
                set_tx_regs();
            end
        end
    endtask

    task automatic rx_frame_test();
        eth_hdr_t hdr;
        eth_beat_t beat;
        beat_word_t exp_word[$];
        beat_word_t word;
        logic [127:0] hdr_bits;
        logic [63:0] wdata;
        int size;
        int i;
        hdr_bits = {rand64(), rand64()};
        hdr = hdr_bits[111:0];
        rx_hdr_q.push_back(hdr);
        for (i = 0; i < 3; i++) begin
            wdata = rand64();
            size = 1 + ((32'($random(seed)) & 32'h7fff_ffff) % 7);
            beat.data = wdata[55:0];
            beat.keep = `ETH_BEAT_BYTES'((8'd1 << size) - 8'd1);
            beat.last = (i == 2);
            rx_beat_q.push_back(beat);
            word.raw = '0;
            word.f.valid = 1'b1;
            word.f.last = beat.last;
            word.f.size = size;
            word.f.data = wdata[55:0];
            exp_word.push_back(word);
        end
        repeat (2) begin
            @(posedge clk);
            #10;
        end
        for (i = 0; i < 3; i++) begin
            read_reg(reg_addr(`ETH_REG_RX_DATA), exp_word[i].raw, `AXI_RESP_OKAY);
            if (i == 0) begin
                read_reg(reg_addr(`ETH_REG_RX_SRC), {16'h0, hdr.src_mac}, `AXI_RESP_OKAY);
                read_reg(reg_addr(`ETH_REG_RX_DST_TYPE), {hdr.eth_type, hdr.dst_mac},
                         `AXI_RESP_OKAY);
            end
        end
        read_reg(reg_addr(`ETH_REG_RX_DATA), 64'h0, `AXI_RESP_OKAY);
        write_reg(reg_addr(`ETH_REG_RX_SRC), rand64(), `AXI_RESP_OKAY);
        write_reg(reg_addr(`ETH_REG_RX_DST_TYPE), rand64(), `AXI_RESP_OKAY);
        write_reg(reg_addr(`ETH_REG_RX_DATA), rand64(), `AXI_RESP_OKAY);
        read_reg(reg_addr(`ETH_REG_RX_SRC), {16'h0, hdr.src_mac}, `AXI_RESP_OKAY);
        read_reg(reg_addr(`ETH_REG_RX_DST_TYPE), {hdr.eth_type, hdr.dst_mac}, `AXI_RESP_OKAY);
        read_reg(reg_addr(`ETH_REG_RX_DATA), 64'h0, `AXI_RESP_OKAY);
    endtask

    // TX sink with random ready
    always @(posedge clk) begin
        #10;
        tx_hdr_ready = ($random(sink_seed) & 3) != 0;
        tx_beat_ready = ($random(sink_seed) & 3) != 0;
    end

    always @(negedge clk) begin
        if (tx_hdr_valid && tx_hdr_ready) begin
            tx_hdr_seen.push_back(tx_hdr);
        end
        if (tx_beat_valid && tx_beat_ready) begin
            tx_beat_seen.push_back(tx_beat);
        end
        rx_hdr_taken = rx_hdr_valid && rx_hdr_ready;
        rx_beat_taken = rx_beat_valid && rx_beat_ready;
    end

    // RX source fed from the queues
    always @(posedge clk) begin
        #10;
        if (rx_hdr_taken) begin
            rx_hdr_q.delete(0);
        end
        if (rx_beat_taken) begin
            rx_beat_q.delete(0);
        end
        rx_hdr_valid = rx_hdr_q.size() != 0;
        rx_beat_valid = rx_beat_q.size() != 0;
        if (rx_hdr_q.size() != 0) begin
            rx_hdr = rx_hdr_q[0];
        end
        if (rx_beat_q.size() != 0) begin
            rx_beat = rx_beat_q[0];
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now("Timeout: the tests did not complete within the watchdog limit");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        aw_valid = 1'b0;
        aw_addr = '0;
        w_valid = 1'b0;
        w_data = '0;
        b_ready = 1'b0;
        ar_valid = 1'b0;
        ar_addr = '0;
        r_ready = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_beat_ready = 1'b0;
        rx_hdr_valid = 1'b0;
        rx_hdr = '0;
        rx_beat_valid = 1'b0;
        rx_beat = '0;
        rx_hdr_taken = 1'b0;
        rx_beat_taken = 1'b0;
        tx_src_m = '0;
        tx_dst_m = '0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        check_value("ready_valid_outputs", {ar_ready, r_valid, aw_ready, w_ready, b_valid,
                    tx_hdr_valid, tx_beat_valid, rx_hdr_ready, rx_beat_ready}, '0);
        @(negedge clk);
        check_value("ar_aw_w_ready", {ar_ready, aw_ready, w_ready}, 3'b111);
        @(posedge clk);
        #10;
        read_reg(reg_addr(`ETH_REG_TX_SRC), 64'h0, `AXI_RESP_OKAY);
        read_reg(reg_addr(`ETH_REG_TX_DST_TYPE), 64'h0, `AXI_RESP_OKAY);

        repeat (4) begin
            set_tx_regs();
            read_reg(reg_addr(`ETH_REG_TX_SRC), tx_src_m, `AXI_RESP_OKAY);
            read_reg(reg_addr(`ETH_REG_TX_DST_TYPE), tx_dst_m, `AXI_RESP_OKAY);
            // Second address waits behind the stalled first response
            issue_ar(reg_addr(`ETH_REG_TX_DST_TYPE));
            issue_ar(reg_addr(`ETH_REG_TX_SRC));
            collect_r(tx_dst_m, `AXI_RESP_OKAY);
            collect_r(tx_src_m, `AXI_RESP_OKAY);
        end

        send_frame(3, 1);
        send_frame(2, 0);
        send_frame(1, 1);
        send_frame(4, 0);
        while (tx_beat_seen.size() < tx_beat_exp.size() ||
               tx_hdr_seen.size() < tx_hdr_exp.size()) begin
            @(posedge clk);
            #10;
        end
        repeat (5) begin
            @(posedge clk);
            #10;
        end
        check_value("tx_hdr count", tx_hdr_seen.size(), tx_hdr_exp.size());
        check_value("tx_beat count", tx_beat_seen.size(), tx_beat_exp.size());
        foreach (tx_hdr_exp[i]) check_value("tx_hdr", tx_hdr_seen[i], tx_hdr_exp[i]);
        foreach (tx_beat_exp[i]) check_value("tx_beat", tx_beat_seen[i], tx_beat_exp[i]);

        read_reg(reg_addr(`ETH_REG_RX_DATA), 64'h0, `AXI_RESP_OKAY);
        rx_frame_test();

        read_reg(reg_addr(`ETH_REG_TX_DATA), 64'h0, `AXI_RESP_SLVERR);
        read_reg(reg_addr(6), 64'h0, `AXI_RESP_SLVERR);
        read_reg(reg_addr(7), 64'h0, `AXI_RESP_SLVERR);
        read_reg(32'h100 | reg_addr(`ETH_REG_TX_SRC), 64'h0, `AXI_RESP_SLVERR);
        read_reg(32'h8000_0000 | reg_addr(`ETH_REG_TX_DST_TYPE), 64'h0, `AXI_RESP_SLVERR);
        write_reg(32'h40 | reg_addr(`ETH_REG_TX_SRC), rand64(), `AXI_RESP_SLVERR);
        write_reg(reg_addr(6), rand64(), `AXI_RESP_SLVERR);
        write_reg(reg_addr(7), rand64(), `AXI_RESP_SLVERR);
        read_reg(reg_addr(`ETH_REG_TX_SRC), tx_src_m, `AXI_RESP_OKAY);
        read_reg(reg_addr(`ETH_REG_TX_DST_TYPE), tx_dst_m, `AXI_RESP_OKAY);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/eth_mmio_pkg.sv
logic/axil_read_channel.sv
logic/axil_write_channel.sv
logic/eth_mmio_control.sv
logic/tx_frame_stager.sv
logic/rx_frame_reader.sv
logic/eth_mmio_top.sv
test/tb_eth_mmio.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_eth_mmio -f filelist.f -o tb_sim \
    || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^TEST PASS$" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
